// ==== Makefile ====
# Verilator build and run of the ADC sample store testbench.

VERILATOR ?= verilator
TOP       ?= tb_adc_store
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/adc_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_capture (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               adc_strb_i,
  input  logic [adc_store_pkg::CHAN_W-1:0]   adc_channel_i,
  input  logic [adc_store_pkg::SAMPLE_W-1:0] adc_result_i,
  input  logic                               rb_pause_i,
  output logic                               ram_we_o,
  output logic [adc_store_pkg::ADDR_W-1:0]   ram_waddr_o,
  output logic [adc_store_pkg::SAMPLE_W-1:0] ram_wdata_o,
  output logic [adc_store_pkg::ADDR_W-1:0]   rb_checkpoint_o,
  output logic [adc_store_pkg::ADDR_W-1:0]   rb_tail_o
);

  import adc_store_pkg::*;

  logic [ADDR_W-1:0] rb_head_q;
  logic [ADDR_W-1:0] rb_tail_q;
  logic [ADDR_W-1:0] rb_checkpoint_q;
  logic              rb_full_q;
  logic [CHAN_W-1:0] chan_prev_q;
  logic              pause_prev_q;

  logic [ADDR_W-1:0] rb_head_next;
  logic [ADDR_W-1:0] rb_tail_next;
  logic [ADDR_W-1:0] rb_head_prev;
  logic              resume_clr;
  logic              sample_wr;

  // Forward and backward steps around the ring.
  assign rb_head_next = (rb_head_q == ADDR_W'(RAM_DEPTH - 1)) ? '0 : rb_head_q + 1'b1;
  assign rb_tail_next = (rb_tail_q == ADDR_W'(RAM_DEPTH - 1)) ? '0 : rb_tail_q + 1'b1;
  assign rb_head_prev = (rb_head_q == '0) ? ADDR_W'(RAM_DEPTH - 1) : rb_head_q - 1'b1;

  // Capture restarts on the cycle after pause is released.
  assign resume_clr = pause_prev_q & ~rb_pause_i;

  // Strobes are dropped while frozen and during the restart cycle.
  assign sample_wr = adc_strb_i & ~rb_pause_i & ~resume_clr;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pause_prev_q <= 1'b0;
    end else begin
      pause_prev_q <= rb_pause_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || resume_clr) begin
      rb_head_q       <= '0;
      rb_tail_q       <= '0;
      rb_checkpoint_q <= '0;
      rb_full_q       <= 1'b0;
      chan_prev_q     <= '0;
    end else if (sample_wr) begin
      rb_head_q   <= rb_head_next;
      chan_prev_q <= adc_channel_i;
      if (rb_head_next == rb_tail_q) begin
        rb_full_q <= 1'b1;
      end
      // Oldest sample is overwritten once the ring is full.
      if (rb_full_q) begin
        rb_tail_q <= rb_tail_next;
      end
      // Channel wrapped, so the previous slot closed a complete set.
      if (adc_channel_i < chan_prev_q) begin
        rb_checkpoint_q <= rb_head_prev;
      end
    end
  end

  assign ram_we_o        = sample_wr;
  assign ram_waddr_o     = rb_head_q;
  assign ram_wdata_o     = adc_result_i;
  assign rb_checkpoint_o = rb_checkpoint_q;
  assign rb_tail_o       = rb_tail_q;

  // Each write moves the write slot one step around the ring.
  a_waddr_step: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    ram_we_o |=> (32'(ram_waddr_o) == (32'($past(ram_waddr_o)) + 1) % RAM_DEPTH)
  );

  // A frozen buffer keeps its pointers across the next edge.
  a_frozen_ring: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    rb_pause_i |=> ($stable(rb_head_q) && $stable(rb_tail_q))
  );

endmodule

`default_nettype wire

// ==== rtl/adc_store_pkg.sv ====
`default_nettype none

package adc_store_pkg;

  // Ring size and address width of the sample RAM.
  localparam int RAM_DEPTH = 512;
  localparam int ADDR_W    = 9;

  // ADC result and channel tag.
  localparam int SAMPLE_W  = 12;
  localparam int CHAN_W    = 5;
  localparam int NUM_CHAN  = 32;

  // Wishbone bus widths.
  localparam int WB_ADR_W  = 16;
  localparam int WB_DAT_W  = 16;

  // Playback control register.
  localparam logic [WB_ADR_W-1:0] REG_RB_CTRL = 16'h0040;

  // Fixed replies of the playback register.
  localparam logic [WB_DAT_W-1:0] RB_IDLE_WORD  = 16'h1000;
  localparam logic [WB_DAT_W-1:0] RB_EMPTY_WORD = 16'hffff;

  // Readout FSM states.
  // RD_RAM covers the registered RAM read, RD_ACK the single ack cycle.
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_RAM,
    RD_ACK
  } readout_state_e;

endpackage

`default_nettype wire

// ==== rtl/adc_store_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_store_top (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [adc_store_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [adc_store_pkg::WB_DAT_W-1:0] wb_dat_i,
  output logic [adc_store_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic                               wb_ack_o,
  input  logic                               adc_strb_i,
  input  logic [adc_store_pkg::CHAN_W-1:0]   adc_channel_i,
  input  logic [adc_store_pkg::SAMPLE_W-1:0] adc_result_i
);

  import adc_store_pkg::*;

  // Capture side to RAM.
  logic                ram_we;
  logic [ADDR_W-1:0]   ram_waddr;
  logic [SAMPLE_W-1:0] ram_wdata;

  // RAM to bus side.
  logic [ADDR_W-1:0]   ram_raddr;
  logic [SAMPLE_W-1:0] ram_rdata;

  // Ring state shared between the two sides.
  logic [ADDR_W-1:0]   rb_checkpoint;
  logic [ADDR_W-1:0]   rb_tail;
  logic                rb_pause;

  adc_capture i_capture (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .adc_strb_i      (adc_strb_i),
    .adc_channel_i   (adc_channel_i),
    .adc_result_i    (adc_result_i),
    .rb_pause_i      (rb_pause),
    .ram_we_o        (ram_we),
    .ram_waddr_o     (ram_waddr),
    .ram_wdata_o     (ram_wdata),
    .rb_checkpoint_o (rb_checkpoint),
    .rb_tail_o       (rb_tail)
  );

  sample_ram i_ram (
    .wb_clk_i (wb_clk_i),
    .we_i     (ram_we),
    .waddr_i  (ram_waddr),
    .wdata_i  (ram_wdata),
    .raddr_i  (ram_raddr),
    .rdata_o  (ram_rdata)
  );

  wb_readout i_readout (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .rb_checkpoint_i (rb_checkpoint),
    .rb_tail_i       (rb_tail),
    .rb_pause_o      (rb_pause),
    .ram_raddr_o     (ram_raddr),
    .ram_rdata_i     (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== rtl/sample_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module sample_ram (
  input  logic                               wb_clk_i,
  input  logic                               we_i,
  input  logic [adc_store_pkg::ADDR_W-1:0]   waddr_i,
  input  logic [adc_store_pkg::SAMPLE_W-1:0] wdata_i,
  input  logic [adc_store_pkg::ADDR_W-1:0]   raddr_i,
  output logic [adc_store_pkg::SAMPLE_W-1:0] rdata_o
);

  import adc_store_pkg::*;

  logic [SAMPLE_W-1:0] mem [RAM_DEPTH];
  logic [SAMPLE_W-1:0] rdata_q;

  // Write port, driven by the capture side.
  always_ff @(posedge wb_clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read port.
  // A read of the slot being written sees the old value.
  always_ff @(posedge wb_clk_i) begin
    rdata_q <= mem[raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/wb_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_readout (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [adc_store_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [adc_store_pkg::WB_DAT_W-1:0] wb_dat_i,
  output logic [adc_store_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic                               wb_ack_o,
  input  logic [adc_store_pkg::ADDR_W-1:0]   rb_checkpoint_i,
  input  logic [adc_store_pkg::ADDR_W-1:0]   rb_tail_i,
  output logic                               rb_pause_o,
  output logic [adc_store_pkg::ADDR_W-1:0]   ram_raddr_o,
  input  logic [adc_store_pkg::SAMPLE_W-1:0] ram_rdata_i
);

  import adc_store_pkg::*;

  // Source of the data word returned with ack.
  typedef enum logic [1:0] {
    REPLY_SAMPLE,
    REPLY_IDLE,
    REPLY_EMPTY,
    REPLY_ZERO
  } reply_sel_e;

  readout_state_e    state_q;
  reply_sel_e        reply_d;
  reply_sel_e        reply_q;
  logic              pause_q;
  logic [ADDR_W-1:0] rb_ptr_q;
  logic [CHAN_W-1:0] chan_q;
  logic              rd_direct_q;

  logic              bus_req;
  logic              ctrl_sel;
  logic              direct_rd;
  logic              ctrl_rd;
  logic              rb_empty;
  logic              slow_req;
  logic [ADDR_W-1:0] chan_back;
  logic [ADDR_W-1:0] direct_addr;
  logic [ADDR_W-1:0] rb_ptr_prev;

  // Request decode, taken only while the FSM is idle.
  assign bus_req   = wb_cyc_i & wb_stb_i & (state_q == RD_IDLE);
  assign ctrl_sel  = (wb_adr_i == REG_RB_CTRL);
  assign direct_rd = (wb_adr_i < WB_ADR_W'(NUM_CHAN)) & ~wb_we_i;
  assign ctrl_rd   = ctrl_sel & ~wb_we_i;
  assign rb_empty  = (rb_ptr_q == rb_tail_i);

  // These go through the RAM and take the longer path.
  assign slow_req = direct_rd | (ctrl_rd & pause_q & ~rb_empty);

  always_comb begin
    if (direct_rd) begin
      reply_d = REPLY_SAMPLE;
    end else if (!ctrl_rd) begin
      reply_d = REPLY_ZERO;
    end else if (!pause_q) begin
      reply_d = REPLY_IDLE;
    end else if (rb_empty) begin
      reply_d = REPLY_EMPTY;
    end else begin
      reply_d = REPLY_SAMPLE;
    end
  end

  // Channel c sits (31 - c) slots behind the checkpoint.
  assign chan_back   = ADDR_W'(NUM_CHAN - 1 - int'(chan_q));
  assign direct_addr = (rb_checkpoint_i >= chan_back) ? rb_checkpoint_i - chan_back :
                       ADDR_W'(RAM_DEPTH - int'(chan_back) + int'(rb_checkpoint_i));

  assign rb_ptr_prev = (rb_ptr_q == '0) ? ADDR_W'(RAM_DEPTH - 1) : rb_ptr_q - 1'b1;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q  <= RD_IDLE;
      pause_q  <= 1'b0;
      rb_ptr_q <= '0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (bus_req) begin
            state_q <= slow_req ? RD_RAM : RD_ACK;
            if (ctrl_sel && wb_we_i) begin
              if (wb_dat_i == '0) begin
                pause_q  <= 1'b1;
                rb_ptr_q <= rb_checkpoint_i;
              end else begin
                pause_q <= 1'b0;
              end
            end
          end
        end
        RD_RAM: begin
          state_q <= RD_ACK;
          // Playback steps back one slot once its sample is read.
          if (!rd_direct_q) begin
            rb_ptr_q <= rb_ptr_prev;
          end
        end
        RD_ACK: begin
          state_q <= RD_IDLE;
        end
        default: begin
          state_q <= RD_IDLE;
        end
      endcase
    end
  end

  // Request details held for the RAM cycle and the reply.
  always_ff @(posedge wb_clk_i) begin
    if (bus_req) begin
      reply_q     <= reply_d;
      chan_q      <= wb_adr_i[CHAN_W-1:0];
      rd_direct_q <= direct_rd;
    end
  end

  assign ram_raddr_o = rd_direct_q ? direct_addr : rb_ptr_q;
  assign rb_pause_o  = pause_q;
  assign wb_ack_o    = (state_q == RD_ACK);

  always_comb begin
    case (reply_q)
      REPLY_SAMPLE: wb_dat_o = WB_DAT_W'(ram_rdata_i);
      REPLY_IDLE:   wb_dat_o = RB_IDLE_WORD;
      REPLY_EMPTY:  wb_dat_o = RB_EMPTY_WORD;
      default:      wb_dat_o = '0;
    endcase
  end

  // Single-cycle ack pulse.
  a_ack_pulse: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o
  );

  // The master still holds its request when ack arrives.
  a_ack_in_cycle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i)
  );

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/adc_store_pkg.sv
rtl/adc_capture.sv
rtl/sample_ram.sv
rtl/wb_readout.sv
rtl/adc_store_top.sv
tb/adc_store_checker.sv
tb/tb_adc_store.sv

// ==== tb/adc_store_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_store_checker (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [adc_store_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [adc_store_pkg::WB_DAT_W-1:0] wb_dat_i,
  input  logic [adc_store_pkg::WB_DAT_W-1:0] dut_dat_i,
  input  logic                               dut_ack_i,
  input  logic                               adc_strb_i,
  input  logic [adc_store_pkg::CHAN_W-1:0]   adc_channel_i,
  input  logic [adc_store_pkg::SAMPLE_W-1:0] adc_result_i,
  output int                                 error_count_o,
  output int                                 check_count_o
);

  import adc_store_pkg::*;

  // Reference copy of the ring.
  logic [SAMPLE_W-1:0] model_mem [RAM_DEPTH];
  logic [ADDR_W-1:0]   m_head;
  logic [ADDR_W-1:0]   m_tail;
  logic [ADDR_W-1:0]   m_chk;
  logic [ADDR_W-1:0]   m_ptr;
  logic                m_full;
  logic                m_pause;
  logic                m_clr_due;
  logic [CHAN_W-1:0]   m_chan_prev;

  // Outstanding bus request.
  logic                pending;
  logic                exp_check;
  logic [WB_DAT_W-1:0] exp_dat;
  int                  exp_lat;
  int                  wait_cnt;
  logic                ack_prev;
  logic                rst_prev;
  logic                pause_old;
  logic                clr_old;
  int                  errors;
  int                  checks;

  function automatic logic [ADDR_W-1:0] step_fwd(input logic [ADDR_W-1:0] slot);
    return ADDR_W'((int'(slot) + 1) % RAM_DEPTH);
  endfunction

  function automatic logic [ADDR_W-1:0] step_back(input logic [ADDR_W-1:0] slot);
    return ADDR_W'((int'(slot) + RAM_DEPTH - 1) % RAM_DEPTH);
  endfunction

  // Channel c of the last complete set lies 31 - c slots before the checkpoint.
  function automatic logic [ADDR_W-1:0] channel_slot(input logic [ADDR_W-1:0] chk,
                                                    input logic [CHAN_W-1:0] chan);
    return ADDR_W'((int'(chk) + RAM_DEPTH - (NUM_CHAN - 1 - int'(chan))) % RAM_DEPTH);
  endfunction

  task automatic clear_ring();
    m_head      = '0;
    m_tail      = '0;
    m_chk       = '0;
    m_full      = 1'b0;
    m_chan_prev = '0;
  endtask

  task automatic store_sample(input logic [CHAN_W-1:0] chan,
                              input logic [SAMPLE_W-1:0] value);
    logic [ADDR_W-1:0] next_head;
    logic              was_full;
    next_head = step_fwd(m_head);
    was_full  = m_full;
    model_mem[m_head] = value;
    if (next_head == m_tail) begin
      m_full = 1'b1;
    end
    if (was_full) begin
      m_tail = step_fwd(m_tail);
    end
    if (chan < m_chan_prev) begin
      m_chk = step_back(m_head);
    end
    m_head      = next_head;
    m_chan_prev = chan;
  endtask

  task automatic accept_request();
    pending   = 1'b1;
    wait_cnt  = 0;
    exp_check = !wb_we_i;
    exp_dat   = '0;
    exp_lat   = 1;
    if (wb_we_i) begin
      if (wb_adr_i == REG_RB_CTRL && wb_dat_i == '0) begin
        m_pause = 1'b1;
        m_ptr   = m_chk;
      end else if (wb_adr_i == REG_RB_CTRL && m_pause) begin
        m_pause   = 1'b0;
        m_clr_due = 1'b1;
      end
    end else if (int'(wb_adr_i) < NUM_CHAN) begin
      exp_dat = WB_DAT_W'(model_mem[channel_slot(m_chk, wb_adr_i[CHAN_W-1:0])]);
      exp_lat = 2;
    end else if (wb_adr_i == REG_RB_CTRL) begin
      if (!m_pause) begin
        exp_dat = RB_IDLE_WORD;
      end else if (m_ptr == m_tail) begin
        exp_dat = RB_EMPTY_WORD;
      end else begin
        exp_dat = WB_DAT_W'(model_mem[m_ptr]);
        exp_lat = 2;
        m_ptr   = step_back(m_ptr);
      end
    end
  endtask

  task automatic check_reply();
    if (!pending) begin
      errors++;
      $display("Error at %0t: ack arrived with no request pending", $time);
    end else begin
      checks++;
      if (wait_cnt != exp_lat) begin
        errors++;
        $display("FAILED at %0t: wb_ack_o latency expected %0d, actual %0d",
                 $time, exp_lat, wait_cnt);
      end
      if (exp_check && dut_dat_i !== exp_dat) begin
        errors++;
        $display("FAILED at %0t: wb_dat_o expected %h, actual %h", $time, exp_dat, dut_dat_i);
      end
      pending = 1'b0;
    end
  endtask

  // Inputs and DUT outputs are sampled on the rising edge.
  always @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      clear_ring();
      m_pause   = 1'b0;
      m_ptr     = '0;
      m_clr_due = 1'b0;
      pending   = 1'b0;
      ack_prev  = 1'b0;
      rst_prev  = 1'b1;
    end else begin
      if (rst_prev && dut_ack_i) begin
        errors++;
        $display("Error at %0t: ack is high right after reset", $time);
      end
      if (dut_ack_i && ack_prev) begin
        errors++;
        $display("Error at %0t: ack stayed high for two cycles", $time);
      end
      // Capture sees the pause state from before this edge.
      pause_old = m_pause;
      clr_old   = m_clr_due;
      m_clr_due = 1'b0;
      if (pending) begin
        wait_cnt++;
      end
      if (dut_ack_i) begin
        check_reply();
      end else if (pending && wait_cnt > exp_lat) begin
        errors++;
        pending = 1'b0;
        $display("Error at %0t: no ack for the pending request", $time);
      end else if (!pending && wb_cyc_i && wb_stb_i) begin
        accept_request();
      end
      if (clr_old) begin
        clear_ring();
      end else if (adc_strb_i && !pause_old) begin
        store_sample(adc_channel_i, adc_result_i);
      end
      rst_prev = 1'b0;
      ack_prev = dut_ack_i;
    end
  end

  initial begin
    errors = 0;
    checks = 0;
  end

  assign error_count_o = errors;
  assign check_count_o = checks;

endmodule

`default_nettype wire

// ==== tb/tb_adc_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_adc_store;

  import adc_store_pkg::*;

  // Rough upper count of ADC and bus transfers, sizes the watchdog.
  localparam int NUM_TRANS   = 1800;
  localparam int WATCHDOG_NS = NUM_TRANS * 8 * 40 + 20000;

  logic                wb_clk;
  logic                wb_rst;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_ack;
  logic                adc_strb;
  logic [CHAN_W-1:0]   adc_channel;
  logic [SAMPLE_W-1:0] adc_result;
  int                  error_count;
  int                  check_count;
  integer              seed;

  adc_store_top i_dut (
    .wb_clk_i      (wb_clk),
    .wb_rst_i      (wb_rst),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .wb_dat_o      (wb_dat_r),
    .wb_ack_o      (wb_ack),
    .adc_strb_i    (adc_strb),
    .adc_channel_i (adc_channel),
    .adc_result_i  (adc_result)
  );

  adc_store_checker i_checker (
    .wb_clk_i      (wb_clk),
    .wb_rst_i      (wb_rst),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .dut_dat_i     (wb_dat_r),
    .dut_ack_i     (wb_ack),
    .adc_strb_i    (adc_strb),
    .adc_channel_i (adc_channel),
    .adc_result_i  (adc_result),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  always #20 wb_clk = ~wb_clk;

  // Channels 0 to n_chan-1 in order, random results and gaps.
  task automatic send_set(input int n_chan);
    int gap;
    for (int ch = 0; ch < n_chan; ch++) begin
      adc_strb    = 1'b1;
      adc_channel = CHAN_W'(ch);
      adc_result  = SAMPLE_W'($random(seed));
      @(posedge wb_clk);
      #2;
      adc_strb = 1'b0;
      gap = int'($unsigned($random(seed)) % 4);
      repeat (gap) begin
        @(posedge wb_clk);
        #2;
      end
    end
  endtask

  task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    // Ack is looked at mid-cycle and the request drops after that edge.
    do begin
      @(negedge wb_clk);
    end while (!wb_ack);
    @(posedge wb_clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_channels(input int n_reads);
    repeat (n_reads) begin
      bus_access(1'b0, WB_ADR_W'($unsigned($random(seed)) % NUM_CHAN), '0);
    end
  endtask

  task automatic read_playback(input int n_reads);
    repeat (n_reads) begin
      bus_access(1'b0, REG_RB_CTRL, '0);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog timeout, the test did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed        = 32'hd575_30b9;
    wb_clk      = 1'b0;
    wb_rst      = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    adc_strb    = 1'b0;
    adc_channel = '0;
    adc_result  = '0;
    repeat (5) @(posedge wb_clk);
    #2;
    wb_rst = 1'b0;

    // Fixed replies before any capture.
    bus_access(1'b0, REG_RB_CTRL, '0);
    bus_access(1'b0, 16'd32, '0);
    bus_access(1'b0, 16'h0041, '0);
    bus_access(1'b0, 16'h1234, '0);
    bus_access(1'b1, 16'd5, 16'h0abc);

    // Enough sets to wrap the ring, each phase followed by direct reads.
    repeat (3) begin
      repeat (6 + int'($unsigned($random(seed)) % 4)) send_set(NUM_CHAN);
      read_channels(20);
    end

    // Frozen buffer ignores new strobes, then the history plays back.
    bus_access(1'b1, REG_RB_CTRL, '0);
    send_set(NUM_CHAN);
    read_channels(20);
    read_playback(520);

    // Partial set after resume gives an empty playback.
    bus_access(1'b1, REG_RB_CTRL, 16'h0001);
    send_set(10);
    bus_access(1'b1, REG_RB_CTRL, '0);
    read_playback(4);

    // One full set, closed by the next channel 0.
    bus_access(1'b1, REG_RB_CTRL, 16'h0001);
    send_set(NUM_CHAN);
    send_set(1);
    bus_access(1'b1, REG_RB_CTRL, '0);
    read_playback(36);
    read_channels(10);
    bus_access(1'b1, REG_RB_CTRL, 16'h0001);
    bus_access(1'b0, REG_RB_CTRL, '0);

    repeat (2) @(posedge wb_clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
